//--- flist.f
design/frame_pkg.sv
design/stream_pkg.sv
design/ip_header_builder.sv
design/payload_fifo.sv
design/crc32_gen.sv
design/frame_sequencer.sv
design/udp_tx_top.sv
tb/tb_clock.sv
tb/frame_sequencer_assertions.sv
tb/udp_tx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module udp_tx_tb -o udp_tx_sim

./obj_dir/udp_tx_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

//--- tb/udp_tx_tb.sv
module udp_tx_tb;

    typedef logic [7:0] byte_q_t[$];

    logic                         clk;
    logic                         rst_i;
    logic                         s_valid_i;
    stream_pkg::byte_beat_t       s_beat_i;
    logic                         s_ready_o;
    logic [stream_pkg::LEN_W-1:0] payload_len_i;
    stream_pkg::endpoint_t        local_ep_i;
    stream_pkg::endpoint_t        remote_ep_i;
    logic                         tx_en_o;
    logic [7:0]                   tx_d_o;

    logic [31:0] lcg_state = 32'd47;
    logic [7:0]  payload_q[$];    // every accepted byte, in order.
    int          frame_len_q[$];  // payload length of each frame still to be seen.
    int          err_cnt = 0;
    int          frames_queued = 0;
    int          frames_seen = 0;

    tb_clock u_clk (.clk_o(clk));

    udp_tx_top dut0 (
        .clk_i        (clk),
        .rst_i        (rst_i),
        .s_valid_i    (s_valid_i),
        .s_beat_i     (s_beat_i),
        .s_ready_o    (s_ready_o),
        .payload_len_i(payload_len_i),
        .local_ep_i   (local_ep_i),
        .remote_ep_i  (remote_ep_i),
        .tx_en_o      (tx_en_o),
        .tx_d_o       (tx_d_o)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ====================
    // expected frame
    // ====================
    function automatic byte_q_t expected_frame(input logic [7:0] pay[$],
                                               input stream_pkg::endpoint_t loc,
                                               input stream_pkg::endpoint_t rem);
        byte_q_t      f;
        logic [335:0] h;
        logic [31:0]  sum;
        logic [31:0]  crc;
        int           n;
        n = pay.size();
        h = {rem.mac, loc.mac, 16'h0800, 8'h45, 8'h00, 16'(n + 28), 16'h0000, 16'h4000,
             8'd64, 8'd17, 16'h0000, loc.ip, rem.ip, loc.port, rem.port, 16'(n + 8), 16'h0000};
        sum = 32'd0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'(h[335 - 8 * (14 + 2 * i) -: 16]);  // IPv4 header starts at byte 14.
        end
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        h[335 - 8 * 24 -: 16] = ~sum[15:0];
        for (int i = 0; i < 7; i++) begin
            f.push_back(8'h55);
        end
        f.push_back(8'hD5);
        for (int i = 0; i < 42; i++) begin
            f.push_back(h[335 - 8 * i -: 8]);
        end
        foreach (pay[i]) begin
            f.push_back(pay[i]);
        end
        crc = 32'hFFFF_FFFF;
        for (int i = 8; i < f.size(); i++) begin
            crc = crc ^ 32'(f[i]);
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
            end
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            f.push_back(crc[8 * i +: 8]);
        end
        return f;
    endfunction

    task automatic check_frame(input logic [7:0] got[$]);
        byte_q_t    exp;
        logic [7:0] pay[$];
        int         n;
        frames_seen++;
        if (frame_len_q.size() == 0) begin
            $display("a frame of %0d bytes was sent with no payload queued", got.size());
            err_cnt++;
        end else begin
            n = frame_len_q.pop_front();
            for (int i = 0; i < n && payload_q.size() > 0; i++) begin
                pay.push_back(payload_q.pop_front());
            end
            exp = expected_frame(pay, local_ep_i, remote_ep_i);
            if (got.size() != exp.size()) begin
                $display("ERROR t=%0t tx_en_o burst length expected %0d actual %0d",
                         $time, exp.size(), got.size());
                err_cnt++;
            end
            for (int i = 0; i < got.size() && i < exp.size(); i++) begin
                if (got[i] !== exp[i]) begin
                    $display("ERROR t=%0t tx_d_o byte %0d expected %02h actual %02h",
                             $time, i, exp[i], got[i]);
                    err_cnt++;
                end
            end
        end
    endtask

    // ====================
    // stimulus tasks
    // ====================
    task automatic send_byte(input logic [7:0] d, input logic last, input logic idle_check);
        int waited;
        waited = 0;
        s_valid_i <= 1'b1;
        s_beat_i  <= '{data: d, last: last};
        do begin
            @(posedge clk);
            waited++;
            if (idle_check && tx_en_o) begin
                $display("ERROR t=%0t tx_en_o expected 0 actual 1", $time);
                err_cnt++;
            end
        end while (!s_ready_o && waited < 200);
        if (!s_ready_o) begin
            $display("s_ready_o stayed low for 200 cycles, a payload byte was not accepted");
            err_cnt++;
        end else begin
            payload_q.push_back(d);
        end
    endtask

    task automatic expect_tx_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (tx_en_o !== 1'b0) begin
                $display("ERROR t=%0t tx_en_o expected 0 actual %b", $time, tx_en_o);
                err_cnt++;
            end
        end
    endtask

    task automatic send_frames(input int n, input int count, input logic idle_check);
        for (int k = 0; k < count; k++) begin
            frame_len_q.push_back(n);
        end
        frames_queued += count;
        for (int i = 0; i < n * count; i++) begin
            if (idle_check && i == n * count - 1) begin
                s_valid_i <= 1'b0;  // the FIFO holds one byte less than the length here.
                expect_tx_quiet(16);
            end
            send_byte(8'(lcg_next() >> 24), (i % n) == n - 1, idle_check);
        end
        s_valid_i <= 1'b0;
    endtask

    task automatic wait_frames(input int limit);
        int waited;
        waited = 0;
        while (frames_seen < frames_queued && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (frames_seen < frames_queued) begin
            $display("only %0d of %0d frames were sent within %0d cycles",
                     frames_seen, frames_queued, limit);
            err_cnt++;
        end
    endtask

    task automatic single_frame(input int n);
        int waited;
        wait_frames(4000);
        payload_len_i <= stream_pkg::LEN_W'(n);
        @(posedge clk);
        send_frames(n, 1, 1'b1);
        waited = 0;
        while (!tx_en_o && waited < 8) begin
            @(posedge clk);
            waited++;
        end
        if (!tx_en_o) begin
            $display("no frame started within 8 cycles of the last payload byte");
            err_cnt++;
        end
    endtask

    initial begin : stimulus
        int n;
        int waited;
        rst_i         <= 1'b1;
        s_valid_i     <= 1'b0;
        s_beat_i      <= '0;
        payload_len_i <= '1;  // longer than anything buffered during reset.
        local_ep_i    <= {lcg_next(), lcg_next(), lcg_next()};
        remote_ep_i   <= {lcg_next(), lcg_next(), lcg_next()};
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        if (tx_en_o !== 1'b0) begin
            $display("ERROR t=%0t tx_en_o expected 0 actual %b", $time, tx_en_o);
            err_cnt++;
        end
        waited = 0;
        while (!s_ready_o && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (!s_ready_o) begin
            $display("s_ready_o did not rise after reset");
            err_cnt++;
        end
        for (int f = 0; f < 8; f++) begin
            if (f == 0) begin
                n = 18;
            end else if (f == 7) begin
                n = 1472;
            end else begin
                n = 18 + int'((lcg_next() >> 8) % 183);
            end
            single_frame(n);
        end
        // two frames queued at once are kept apart by the gap.
        wait_frames(4000);
        n = 18 + int'((lcg_next() >> 8) % 183);
        payload_len_i <= stream_pkg::LEN_W'(n);
        @(posedge clk);
        send_frames(n, 2, 1'b0);
        // fill the FIFO to its depth before the pops begin.
        wait_frames(4000);
        payload_len_i <= '1;
        @(posedge clk);
        send_frames(2047, 1, 1'b0);
        send_byte(8'(lcg_next() >> 24), 1'b0, 1'b0);
        s_valid_i <= 1'b0;
        waited = 0;
        while (s_ready_o && waited < 8) begin
            @(posedge clk);
            waited++;
        end
        if (s_ready_o) begin
            $display("s_ready_o stayed high with 2048 bytes in the FIFO");
            err_cnt++;
        end
        wait_frames(6000);
        repeat (20) @(posedge clk);
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : compare
        logic [7:0] got[$];
        int         low_run;
        low_run = 100;
        forever begin
            @(posedge clk);
            if (tx_en_o === 1'b1) begin
                if (got.size() == 0 && low_run < 13) begin
                    $display("ERROR t=%0t tx_en_o low cycles expected >= 13 actual %0d",
                             $time, low_run);
                    err_cnt++;
                end
                got.push_back(tx_d_o);
                low_run = 0;
            end else begin
                if (got.size() != 0) begin
                    check_frame(got);
                    got.delete();
                end
                low_run++;
            end
        end
    end

endmodule

//--- tb/frame_sequencer_assertions.sv
module frame_sequencer_assertions (
    input logic                         clk_i,
    input logic                         rst_i,
    input logic                         tx_en_i,
    input logic                         pop_i,
    input logic [stream_pkg::CNT_W-1:0] fifo_count_i,
    input logic                         head_last_i,
    input logic                         last_byte_i
);

    quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !tx_en_i)
        else $error("tx_en_o high in the cycle after a reset cycle");

    no_pop_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> (fifo_count_i != '0))
        else $error("payload pop while the FIFO is empty");

    // the stream's last flag must line up with the length counter.
    last_on_final_pop: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> (head_last_i == last_byte_i))
        else $error("last flag does not match the final payload pop");

endmodule

bind frame_sequencer frame_sequencer_assertions u_checks (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tx_en_i     (tx_en_o),
    .pop_i       (fifo_pop),
    .fifo_count_i(fifo_count),
    .head_last_i (head_beat.last),
    .last_byte_i (cnt_done)
);

//--- tb/tb_clock.sv
module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #20 clk_o = ~clk_o;  // period of 40.

endmodule

//--- design/udp_tx_top.sv
module udp_tx_top (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         s_valid_i,
    input  stream_pkg::byte_beat_t       s_beat_i,
    output logic                         s_ready_o,
    input  logic [stream_pkg::LEN_W-1:0] payload_len_i,
    input  stream_pkg::endpoint_t        local_ep_i,
    input  stream_pkg::endpoint_t        remote_ep_i,
    output logic                         tx_en_o,
    output logic [7:0]                   tx_d_o
);

    frame_sequencer u_seq (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .s_valid_i    (s_valid_i),
        .s_beat_i     (s_beat_i),
        .s_ready_o    (s_ready_o),
        .payload_len_i(payload_len_i),
        .local_ep_i   (local_ep_i),
        .remote_ep_i  (remote_ep_i),
        .tx_en_o      (tx_en_o),
        .tx_d_o       (tx_d_o)
    );

endmodule

//--- design/frame_sequencer.sv
module frame_sequencer (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         s_valid_i,
    input  stream_pkg::byte_beat_t       s_beat_i,
    output logic                         s_ready_o,
    input  logic [stream_pkg::LEN_W-1:0] payload_len_i,
    input  stream_pkg::endpoint_t        local_ep_i,
    input  stream_pkg::endpoint_t        remote_ep_i,
    output logic                         tx_en_o,
    output logic [7:0]                   tx_d_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_HEADER,
        ST_PAYLOAD,
        ST_FCS,
        ST_GAP
    } state_t;

    state_t                       state_q;
    state_t                       state_d;
    logic [stream_pkg::LEN_W-1:0] cnt_q;
    logic [stream_pkg::LEN_W-1:0] state_len;
    logic [stream_pkg::LEN_W-1:0] len_q;
    logic                         cnt_done;
    frame_pkg::hdr_word_u         header;
    frame_pkg::hdr_word_u         header_q;
    stream_pkg::byte_beat_t       head_beat;
    logic [stream_pkg::CNT_W-1:0] fifo_count;
    logic                         fifo_pop;
    logic [31:0]                  crc;
    logic [31:0]                  fcs_q;
    logic                         crc_en;
    logic                         crc_clear;
    logic                         tx_valid;
    logic [7:0]                   tx_data;

    ip_header_builder u_hdr (
        .local_ep_i   (local_ep_i),
        .remote_ep_i  (remote_ep_i),
        .payload_len_i(payload_len_i),
        .header_o     (header)
    );

    payload_fifo u_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_valid_i(s_valid_i),
        .wr_beat_i (s_beat_i),
        .wr_ready_o(s_ready_o),
        .rd_beat_o (head_beat),
        .rd_pop_i  (fifo_pop),
        .count_o   (fifo_count)
    );

    crc32_gen u_crc (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(crc_clear),
        .en_i   (crc_en),
        .data_i (tx_data),
        .crc_o  (crc)
    );

    // ====================
    // state machine
    // ====================
    always_comb begin
        case (state_q)
            ST_PREAMBLE: state_len = stream_pkg::LEN_W'(frame_pkg::PREAMBLE_LEN);
            ST_HEADER:   state_len = stream_pkg::LEN_W'(frame_pkg::HDR_LEN);
            ST_PAYLOAD:  state_len = len_q;
            ST_FCS:      state_len = stream_pkg::LEN_W'(frame_pkg::FCS_LEN);
            ST_GAP:      state_len = stream_pkg::LEN_W'(frame_pkg::GAP_LEN);
            default:     state_len = stream_pkg::LEN_W'(1);  // delimiter and idle.
        endcase
    end

    assign cnt_done = (cnt_q == state_len - 1'b1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (fifo_count >= stream_pkg::CNT_W'(payload_len_i)) begin
                    state_d = ST_PREAMBLE;  // whole payload is already buffered.
                end
            end
            ST_PREAMBLE: if (cnt_done) state_d = ST_SFD;
            ST_SFD:      if (cnt_done) state_d = ST_HEADER;
            ST_HEADER:   if (cnt_done) state_d = ST_PAYLOAD;
            ST_PAYLOAD:  if (cnt_done) state_d = ST_FCS;
            ST_FCS:      if (cnt_done) state_d = ST_GAP;
            ST_GAP:      if (cnt_done) state_d = ST_IDLE;
            default:     state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= (state_d != state_q) ? '0 : cnt_q + 1'b1;
        end
    end

    // ====================
    // byte select
    // ====================
    always_comb begin
        tx_valid = 1'b1;
        tx_data  = 8'h00;
        case (state_q)
            ST_PREAMBLE: tx_data = frame_pkg::PREAMBLE_BYTE;
            ST_SFD:      tx_data = frame_pkg::SFD_BYTE;
            ST_HEADER:   tx_data = header_q.bytes[frame_pkg::HDR_LEN-1];
            ST_PAYLOAD:  tx_data = head_beat.data;
            ST_FCS:      tx_data = (cnt_q == '0) ? crc[7:0] : fcs_q[7:0];
            default:     tx_valid = 1'b0;
        endcase
    end

    assign fifo_pop  = (state_q == ST_PAYLOAD);
    assign crc_en    = (state_q == ST_HEADER) || (state_q == ST_PAYLOAD);
    assign crc_clear = (state_q == ST_IDLE);

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE) begin
            header_q <= header;         // the last idle cycle holds the frame's values.
            len_q    <= payload_len_i;
        end else if (state_q == ST_HEADER) begin
            header_q.bytes <= {header_q.bytes[frame_pkg::HDR_LEN-2:0], 8'h00};
        end
        if (state_q == ST_FCS) begin
            fcs_q <= (cnt_q == '0) ? (crc >> 8) : (fcs_q >> 8);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en_o <= 1'b0;
        end else begin
            tx_en_o <= tx_valid;
        end
        tx_d_o <= tx_data;
    end

endmodule

//--- design/crc32_gen.sv
module crc32_gen (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // one bit per step, least significant bit first.
    always_comb begin
        crc_next = crc_q ^ {24'h0, data_i};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ frame_pkg::CRC_POLY_REFLECTED;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= frame_pkg::CRC_RESIDUE_INIT;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    assign crc_o = ~crc_q;

endmodule

//--- design/payload_fifo.sv
module payload_fifo (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         wr_valid_i,
    input  stream_pkg::byte_beat_t       wr_beat_i,
    output logic                         wr_ready_o,
    output stream_pkg::byte_beat_t       rd_beat_o,
    input  logic                         rd_pop_i,
    output logic [stream_pkg::CNT_W-1:0] count_o
);

    stream_pkg::byte_beat_t         mem [stream_pkg::FIFO_DEPTH];
    logic [stream_pkg::FIFO_AW-1:0] wr_ptr_q;
    logic [stream_pkg::FIFO_AW-1:0] rd_ptr_q;
    logic [stream_pkg::CNT_W-1:0]   count_q;
    logic [stream_pkg::CNT_W-1:0]   count_d;
    logic                           ready_q;
    logic                           push;
    logic                           pop;

    assign push    = wr_valid_i && ready_q;
    assign pop     = rd_pop_i && (count_q != '0);
    assign count_d = count_q + stream_pkg::CNT_W'(push) - stream_pkg::CNT_W'(pop);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ready_q  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two, pointers wrap.
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_d;
            ready_q <= (count_d != stream_pkg::CNT_W'(stream_pkg::FIFO_DEPTH));
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_beat_i;
        end
    end

    assign rd_beat_o  = mem[rd_ptr_q];  // head is visible before the pop.
    assign wr_ready_o = ready_q;
    assign count_o    = count_q;

endmodule

//--- design/ip_header_builder.sv
module ip_header_builder (
    input  stream_pkg::endpoint_t         local_ep_i,
    input  stream_pkg::endpoint_t         remote_ep_i,
    input  logic [stream_pkg::LEN_W-1:0]  payload_len_i,
    output frame_pkg::hdr_word_u          header_o
);

    frame_pkg::eth_ip_udp_hdr_t                     hdr_base;
    logic [$bits(frame_pkg::eth_ip_udp_hdr_t)-1:0] hdr_bits;
    logic [19:0]                                    sum;
    logic [16:0]                                    fold;
    logic [15:0]                                    csum;

    always_comb begin
        hdr_base            = '0;  // identification and both checksums stay zero.
        hdr_base.dst_mac    = remote_ep_i.mac;
        hdr_base.src_mac    = local_ep_i.mac;
        hdr_base.ethertype  = frame_pkg::ETHERTYPE_IPV4;
        hdr_base.ver_ihl    = frame_pkg::IP_VER_IHL;
        hdr_base.total_len  = 16'(payload_len_i) + 16'(frame_pkg::IP_UDP_OVERHEAD);
        hdr_base.flags_frag = frame_pkg::IP_FLAGS_DF;
        hdr_base.ttl        = frame_pkg::IP_TTL;
        hdr_base.protocol   = frame_pkg::IP_PROTO_UDP;
        hdr_base.src_ip     = local_ep_i.ip;
        hdr_base.dst_ip     = remote_ep_i.ip;
        hdr_base.src_port   = local_ep_i.port;
        hdr_base.dst_port   = remote_ep_i.port;
        hdr_base.udp_len    = 16'(payload_len_i) + 16'(frame_pkg::UDP_HDR_LEN);
    end

    assign hdr_bits = hdr_base;

    // the IPv4 header sits directly above the UDP header in the word.
    always_comb begin
        sum = '0;
        for (int i = 0; i < frame_pkg::IP_HDR_LEN / 2; i++) begin
            sum = sum + 20'(hdr_bits[frame_pkg::UDP_HDR_LEN*8 + 16*i +: 16]);
        end
    end

    assign fold = 17'(sum[15:0]) + 17'(sum[19:16]);     // first end-around carry.
    assign csum = ~(fold[15:0] + 16'(fold[16]));

    always_comb begin
        header_o.fields         = hdr_base;
        header_o.fields.ip_csum = csum;
    end

endmodule

//--- design/stream_pkg.sv
package stream_pkg;

    localparam int LEN_W      = 11;
    localparam int FIFO_DEPTH = 2048;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = 12;  // holds the full count of FIFO_DEPTH.

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
    } endpoint_t;

endpackage

//--- design/frame_pkg.sv
package frame_pkg;

    // ====================
    // frame field lengths
    // ====================
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam int         PREAMBLE_LEN  = 7;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;
    localparam int         HDR_LEN       = 42;
    localparam int         FCS_LEN       = 4;
    localparam int         GAP_LEN       = 12;

    // ====================
    // protocol constants
    // ====================
    localparam logic [15:0] ETHERTYPE_IPV4  = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL      = 8'h45;  // version 4, five words of header.
    localparam logic [15:0] IP_FLAGS_DF     = 16'h4000;
    localparam logic [7:0]  IP_TTL          = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP    = 8'd17;
    localparam int          IP_UDP_OVERHEAD = 28;
    localparam int          UDP_HDR_LEN     = 8;
    localparam int          IP_HDR_LEN      = IP_UDP_OVERHEAD - UDP_HDR_LEN;

    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB88320;
    localparam logic [31:0] CRC_RESIDUE_INIT   = 32'hFFFF_FFFF;

    // fields in wire order, the first byte on the wire is the top byte.
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] ip_csum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } eth_ip_udp_hdr_t;

    typedef union packed {
        eth_ip_udp_hdr_t          fields;
        logic [HDR_LEN-1:0][7:0] bytes;
    } hdr_word_u;

endpackage
